/* tests/async_fifo_tests.txt */
# columns: test name, operation, hex value
# W write value, R read and expect value, F fill from value, D drain value words, P traffic of value words
order_w0 W 11
order_w1 W 22
order_w2 W 33
order_r0 R 11
order_r1 R 22
order_w3 W 44
order_r2 R 33
order_r3 R 44
empty_d0 D 0
fill_f0 F a0
fill_d0 D 10
single_w0 W 5a
single_r0 R 5a
fill_f1 F 30
part_r0 R 30
part_r1 R 31
fill_d1 D e
backlog_w0 W 77
traffic_p0 P c8
traffic_d0 D 1
traffic_p1 P 100
traffic_d1 D 0

/* async_fifo.f */
+incdir+logic
logic/async_fifo_pkg.sv
logic/fifo_dual_port_ram.sv
logic/fifo_wr_ptr_ctrl.sv
logic/fifo_rd_ptr_ctrl.sv
logic/async_fifo.sv
tests/async_fifo_tb.sv

/* Bender.yml */
package:
  name: async_fifo

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/async_fifo_pkg.sv
      - logic/fifo_dual_port_ram.sv
      - logic/fifo_wr_ptr_ctrl.sv
      - logic/fifo_rd_ptr_ctrl.sv
      - logic/async_fifo.sv

  - target: test
    include_dirs:
      - logic
    files:
      - tests/async_fifo_tb.sv

/* tests/async_fifo_tb.sv */
`timescale 1ns/1ps
`include "async_fifo_params.svh"

module async_fifo_tb;

  import async_fifo_pkg::*;

  localparam int WAIT_LIMIT = 64; // clocks allowed for any single flag wait.

  logic       wr_clk;
  logic       wr_rst_n;
  logic       wr_en;
  fifo_data_t wr_data;
  logic       full;
  logic       afull;
  logic       rd_clk;
  logic       rd_rst_n;
  logic       rd_en;
  fifo_data_t rd_data;
  logic       empty;
  logic       aempty;

  fifo_data_t  model_q[$]; // words the DUT should hold, oldest first.
  fifo_data_t  last_word;  // the word rd_data should show after the latest read.
  logic [31:0] gap_seed;

  async_fifo DUT (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full),
    .afull    (afull),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #20 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #28 rd_clk = ~rd_clk; // 56 ns, drifts against the write clock.
  end

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic fifo_data_t pop_expected();
    fifo_data_t word;
    word      = model_q.pop_front();
    last_word = word;
    return word;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input string test, input string what,
                       input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Mismatch %s %s: expected %0h, actual %0h",
                          test, what, expected, actual));
    end
  endtask

  // long enough for both Gray pointers to cross their synchronizers.
  task automatic settle();
    repeat (4) @(posedge rd_clk);
    repeat (4) @(posedge wr_clk);
    #2;
  endtask

  task automatic write_word(input string test, input fifo_data_t value);
    int cycles;
    cycles = 0;
    @(posedge wr_clk);
    #2;
    while (full) begin
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run($sformatf("%s: full never went low within %0d write clocks",
                            test, WAIT_LIMIT));
      end
      @(posedge wr_clk);
      #2;
    end
    wr_en   = 1'b1;
    wr_data = value;
    @(posedge wr_clk); // full was low before this edge, so the word is taken.
    #2;
    wr_en = 1'b0;
    model_q.push_back(value);
  endtask

  task automatic read_word(input string test, output fifo_data_t got);
    int cycles;
    cycles = 0;
    @(posedge rd_clk);
    #2;
    while (empty) begin
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run($sformatf("%s: empty never went low within %0d read clocks",
                            test, WAIT_LIMIT));
      end
      @(posedge rd_clk);
      #2;
    end
    rd_en = 1'b1;
    @(posedge rd_clk);
    #2;
    rd_en = 1'b0;
    got = rd_data; // loaded on the accepting edge and held until the next read.
  endtask

  task automatic fill_until_full(input string test, input logic [31:0] base);
    int i;
    i = 0;
    settle();
    while (model_q.size() < `FIFO_DEPTH) begin
      write_word(test, fifo_data_t'(base + i));
      i++;
      check(test, "afull", model_q.size() >= `FIFO_AFULL, afull);
      check(test, "full", model_q.size() == `FIFO_DEPTH, full);
    end
    // this word must be dropped.
    @(posedge wr_clk);
    #2;
    wr_en   = 1'b1;
    wr_data = ~fifo_data_t'(base);
    @(posedge wr_clk);
    #2;
    wr_en = 1'b0;
    check(test, "full after extra write", 1, full);
  endtask

  task automatic drain(input string test, input logic [31:0] words);
    fifo_data_t got;
    int count;
    count = 0;
    settle();
    check(test, "empty", model_q.size() == 0, empty);
    check(test, "aempty", model_q.size() <= `FIFO_AEMPTY, aempty);
    while (model_q.size() > 0) begin
      read_word(test, got);
      check(test, "rd_data", pop_expected(), got);
      count++;
      check(test, "aempty", model_q.size() <= `FIFO_AEMPTY, aempty);
      check(test, "empty", model_q.size() == 0, empty);
    end
    check(test, "word count", words, count);
    @(posedge rd_clk);
    #2;
    rd_en = 1'b1;
    @(posedge rd_clk);
    #2;
    rd_en = 1'b0;
    check(test, "rd_data after read while empty", last_word, rd_data);
    check(test, "empty after read while empty", 1, empty);
  endtask

  task automatic run_traffic(input string test, input int words);
    logic [31:0] wr_seed;
    logic [31:0] rd_seed;
    wr_seed  = xorshift(gap_seed);
    rd_seed  = xorshift(wr_seed);
    gap_seed = rd_seed;
    fork
      begin : writer
        for (int i = 0; i < words; i++) begin
          wr_seed = xorshift(wr_seed);
          repeat (wr_seed[1:0]) @(posedge wr_clk);
          write_word(test, fifo_data_t'(wr_seed >> 8));
        end
      end
      begin : reader
        fifo_data_t got;
        for (int i = 0; i < words; i++) begin
          rd_seed = xorshift(rd_seed);
          repeat (rd_seed[1:0]) @(posedge rd_clk);
          read_word(test, got);
          check(test, "rd_data", pop_expected(), got);
        end
      end
    join
  endtask

  task automatic run_op(input string test, input string op, input logic [31:0] value);
    fifo_data_t got;
    case (op)
      "W": write_word(test, fifo_data_t'(value));
      "R": begin
        read_word(test, got);
        check(test, "rd_data", value, got);
        check(test, "model order", pop_expected(), got);
      end
      "F": fill_until_full(test, value);
      "D": drain(test, value);
      "P": run_traffic(test, value);
      default: abort_run($sformatf("%s: unknown operation %s in the test file", test, op));
    endcase
  endtask

  initial begin
    int fd;
    int fields;
    string line;
    string test;
    string op;
    logic [31:0] value;
    wr_en     = 1'b0;
    wr_data   = '0;
    rd_en     = 1'b0;
    wr_rst_n  = 1'b0;
    rd_rst_n  = 1'b0;
    gap_seed  = 32'h9283;
    last_word = '0; // rd_data comes out of reset cleared.
    repeat (3) @(posedge wr_clk);
    #2;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    check("reset", "empty", 1, empty);
    check("reset", "aempty", 1, aempty);
    check("reset", "full", 0, full);
    check("reset", "afull", 0, afull);
    check("reset", "rd_data", 0, rd_data);
    fd = $fopen("tests/async_fifo_tests.txt", "r");
    if (fd == 0) begin
      abort_run("could not open tests/async_fifo_tests.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) break;
      if (line.len() == 0 || line.getc(0) == "#") continue; // header lines.
      fields = $sscanf(line, "%s %s %h", test, op, value);
      if (fields != 3) continue;
      run_op(test, op, value);
      gap_seed = xorshift(gap_seed);
      repeat (gap_seed[1:0]) @(posedge wr_clk);
    end
    $fclose(fd);
    $display("Everything OK");
    $finish;
  end

endmodule

/* logic/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo (
  // write domain.
  input  logic                       wr_clk,
  input  logic                       wr_rst_n,
  input  logic                       wr_en,
  input  async_fifo_pkg::fifo_data_t wr_data,
  output logic                       full,
  output logic                       afull,
  // read domain.
  input  logic                       rd_clk,
  input  logic                       rd_rst_n,
  input  logic                       rd_en,
  output async_fifo_pkg::fifo_data_t rd_data,
  output logic                       empty,
  output logic                       aempty
);

  import async_fifo_pkg::*;

  logic       wr_accept;
  fifo_addr_t wr_addr;
  fifo_ptr_t  wr_ptr_gray; // crosses to the read side.

  logic       rd_accept;
  fifo_addr_t rd_addr;
  fifo_ptr_t  rd_ptr_gray; // crosses to the write side.

  fifo_wr_ptr_ctrl u_wr_ptr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_accept   (wr_accept),
    .wr_addr     (wr_addr),
    .wr_ptr_gray (wr_ptr_gray),
    .full        (full),
    .afull       (afull)
  );

  fifo_rd_ptr_ctrl u_rd_ptr_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_accept   (rd_accept),
    .rd_addr     (rd_addr),
    .rd_ptr_gray (rd_ptr_gray),
    .empty       (empty),
    .aempty      (aempty)
  );

  fifo_dual_port_ram u_ram (
    .wr_clk    (wr_clk),
    .wr_accept (wr_accept),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_accept (rd_accept),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

endmodule

/* logic/fifo_rd_ptr_ctrl.sv */
`timescale 1ns/1ps
`include "async_fifo_params.svh"

module fifo_rd_ptr_ctrl (
  input  logic                       rd_clk,
  input  logic                       rd_rst_n,
  input  logic                       rd_en,
  input  async_fifo_pkg::fifo_ptr_t  wr_ptr_gray,
  output logic                       rd_accept,
  output async_fifo_pkg::fifo_addr_t rd_addr,
  output async_fifo_pkg::fifo_ptr_t  rd_ptr_gray,
  output logic                       empty,
  output logic                       aempty
);

  import async_fifo_pkg::*;

  fifo_ptr_t rd_ptr_bin;
  fifo_ptr_t rd_ptr_bin_next;

  fifo_ptr_t wr_gray_meta;    // first synchronizer stage.
  fifo_ptr_t wr_gray_sync;    // second synchronizer stage.
  fifo_ptr_t wr_ptr_bin_sync;

  fifo_ptr_t fill_next;

  assign rd_accept = rd_en & ~empty; // a read while empty is dropped.

  assign rd_ptr_bin_next = rd_ptr_bin + fifo_ptr_t'(rd_accept);

  assign rd_addr = rd_ptr_bin[$bits(fifo_addr_t)-1:0];

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr_bin  <= rd_ptr_bin_next;
      rd_ptr_gray <= bin_to_gray(rd_ptr_bin_next);
    end
  end

  // write pointer crosses into the read domain.
  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      wr_gray_meta <= '0;
      wr_gray_sync <= '0;
    end else begin
      wr_gray_meta <= wr_ptr_gray;
      wr_gray_sync <= wr_gray_meta;
    end
  end

  assign wr_ptr_bin_sync = gray_to_bin(wr_gray_sync);

  // the synchronized write pointer lags, so this level never overestimates.
  assign fill_next = wr_ptr_bin_sync - rd_ptr_bin_next;

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1; // nothing stored out of reset.
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_ptr_bin_next == wr_ptr_bin_sync);
      aempty <= (fill_next <= fifo_ptr_t'(`FIFO_AEMPTY));
    end
  end

endmodule

/* logic/fifo_wr_ptr_ctrl.sv */
`timescale 1ns/1ps
`include "async_fifo_params.svh"

module fifo_wr_ptr_ctrl (
  input  logic                       wr_clk,
  input  logic                       wr_rst_n,
  input  logic                       wr_en,
  input  async_fifo_pkg::fifo_ptr_t  rd_ptr_gray,
  output logic                       wr_accept,
  output async_fifo_pkg::fifo_addr_t wr_addr,
  output async_fifo_pkg::fifo_ptr_t  wr_ptr_gray,
  output logic                       full,
  output logic                       afull
);

  import async_fifo_pkg::*;

  fifo_ptr_t wr_ptr_bin;
  fifo_ptr_t wr_ptr_bin_next;

  fifo_ptr_t rd_gray_meta;    // first synchronizer stage.
  fifo_ptr_t rd_gray_sync;    // second synchronizer stage.
  fifo_ptr_t rd_ptr_bin_sync;

  fifo_ptr_t fill_next;

  assign wr_accept = wr_en & ~full; // a write while full is dropped.

  assign wr_ptr_bin_next = wr_ptr_bin + fifo_ptr_t'(wr_accept);

  assign wr_addr = wr_ptr_bin[$bits(fifo_addr_t)-1:0]; // wrap bit is not part of the address.

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr_bin  <= wr_ptr_bin_next;
      wr_ptr_gray <= bin_to_gray(wr_ptr_bin_next); // registered, so only one bit moves per edge.
    end
  end

  // read pointer crosses into the write domain.
  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      rd_gray_meta <= '0;
      rd_gray_sync <= '0;
    end else begin
      rd_gray_meta <= rd_ptr_gray;
      rd_gray_sync <= rd_gray_meta;
    end
  end

  assign rd_ptr_bin_sync = gray_to_bin(rd_gray_sync);

  // the synchronized read pointer lags, so this level never underestimates.
  assign fill_next = wr_ptr_bin_next - rd_ptr_bin_sync;

  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (fill_next == fifo_ptr_t'(`FIFO_DEPTH)); // equal address, opposite wrap bit.
      afull <= (fill_next >= fifo_ptr_t'(`FIFO_AFULL));
    end
  end

endmodule

/* logic/fifo_dual_port_ram.sv */
`timescale 1ns/1ps
`include "async_fifo_params.svh"

module fifo_dual_port_ram (
  input  logic                       wr_clk,
  input  logic                       wr_accept,
  input  async_fifo_pkg::fifo_addr_t wr_addr,
  input  async_fifo_pkg::fifo_data_t wr_data,
  input  logic                       rd_clk,
  input  logic                       rd_rst_n,
  input  logic                       rd_accept,
  input  async_fifo_pkg::fifo_addr_t rd_addr,
  output async_fifo_pkg::fifo_data_t rd_data
);

  import async_fifo_pkg::*;

  fifo_data_t mem [`FIFO_DEPTH]; // storage array, maps onto a block memory.

  // write port.
  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read port with registered output. rd_data holds between accepted reads.
  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_accept) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* logic/async_fifo_pkg.sv */
`include "async_fifo_params.svh"

package async_fifo_pkg;

  // pointers carry one extra wrap bit above the address.
  localparam int unsigned FIFO_PTR_WIDTH = `FIFO_ADDR_WIDTH + 1;

  typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_data_t;
  typedef logic [`FIFO_ADDR_WIDTH-1:0] fifo_addr_t;
  typedef logic [FIFO_PTR_WIDTH-1:0]   fifo_ptr_t;

  function automatic fifo_ptr_t bin_to_gray(input fifo_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic fifo_ptr_t gray_to_bin(input fifo_ptr_t gray);
    fifo_ptr_t bin;
    bin[FIFO_PTR_WIDTH-1] = gray[FIFO_PTR_WIDTH-1];
    for (int i = FIFO_PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i]; // each binary bit folds in all Gray bits above it.
    end
    return bin;
  endfunction

endpackage

/* logic/async_fifo_params.svh */
`ifndef ASYNC_FIFO_PARAMS_SVH
`define ASYNC_FIFO_PARAMS_SVH

// payload width in bits.
`define FIFO_DATA_WIDTH 8

// number of entries. must be a power of two.
`define FIFO_DEPTH 16

// memory address width, log2 of the depth.
`define FIFO_ADDR_WIDTH 4

// write-side fill level at or above which afull is set.
`define FIFO_AFULL 15

// read-side fill level at or below which aempty is set.
`define FIFO_AEMPTY 1

`endif
